// ==== dv/tb_rv_core.sv ====
`include "rv_core_params.svh"

module tb_rv_core import rv_core_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 16;
  localparam int N_PROG          = 23;
  localparam int N_EXP           = 18;
  localparam int N_TAKEN         = 2;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * N_EXP + 20;

  localparam logic [`XLEN-1:0] BOOT_ADDR = 32'h0000_0080;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic [`XLEN-1:0]       boot_addr;
  logic [`XLEN-1:0]       instr_addr;
  instr_u                 instr;
  logic                   perf_sel;
  logic [`PERF_CNT_W-1:0] perf_data;
  logic                   commit_valid;
  commit_t                commit;

  logic [`XLEN-1:0] prog_mem  [N_PROG];
  logic [`XLEN-1:0] exp_pc    [N_EXP];
  logic [`XLEN-1:0] exp_rd    [N_EXP];
  logic [`XLEN-1:0] exp_we    [N_EXP];
  logic [`XLEN-1:0] exp_wdata [N_EXP];
  logic [`XLEN-1:0] prog_offset;
  int               n_words    = 0;
  int               n_expected = 0;

  rv_core rv_core_i (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .boot_addr_i    ( boot_addr    ),
    .instr_addr_o   ( instr_addr   ),
    .instr_i        ( instr        ),
    .perf_sel_i     ( perf_sel     ),
    .perf_data_o    ( perf_data    ),
    .commit_valid_o ( commit_valid ),
    .commit_o       ( commit       )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Instruction memory, all zero (illegal) outside the program
  assign prog_offset = instr_addr - BOOT_ADDR;
  assign instr = (instr_addr >= BOOT_ADDR && prog_offset < 32'(N_PROG * 4) &&
                  prog_offset[1:0] == 2'b00) ? prog_mem[prog_offset[6:2]] : '0;

  // --------------------------------------------------
  // RV32I encoders
  // --------------------------------------------------
  function automatic logic [31:0] enc_r(logic [6:0] funct7, logic [2:0] funct3,
                                        int rd, int rs1, int rs2);
    return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_addi(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_lui(int rd, int imm20);
    return {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  // funct3 0 is BEQ, 1 is BNE
  function automatic logic [31:0] enc_branch(int funct3, int rs1, int rs2, int offset);
    return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3[2:0],
            offset[4:1], offset[11], 7'b1100011};
  endfunction

  task automatic add_word(input logic [31:0] word);
    prog_mem[n_words] = word;
    n_words++;
  endtask

  task automatic add_expected(input logic [31:0] pc, input logic [31:0] rd,
                              input logic [31:0] we, input logic [31:0] wdata);
    exp_pc[n_expected]    = pc;
    exp_rd[n_expected]    = rd;
    exp_we[n_expected]    = we;
    exp_wdata[n_expected] = wdata;
    n_expected++;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // --------------------------------------------------
  // Program and expected commits
  // --------------------------------------------------
  task automatic load_tables();
    add_word(enc_addi(1, 0, 5));                 // 0x80 x1 = 5
    add_word(enc_addi(2, 1, 3));                 // 0x84 x2 = 8, bypass of x1
    add_word(enc_r(7'h00, 3'b000, 3, 1, 2));     // 0x88 ADD x3 = 13
    add_word(enc_r(7'h20, 3'b000, 4, 3, 1));     // 0x8c SUB x4 = 8
    add_word(enc_lui(5, 20'h12345));             // 0x90 LUI x5
    add_word(enc_r(7'h00, 3'b100, 6, 5, 3));     // 0x94 XOR x6
    add_word(enc_r(7'h00, 3'b110, 7, 5, 1));     // 0x98 OR x7
    add_word(enc_r(7'h00, 3'b111, 8, 6, 7));     // 0x9c AND x8
    add_word(enc_addi(0, 1, 7));                 // 0xa0 write to x0 is dropped
    add_word(enc_r(7'h00, 3'b000, 9, 0, 1));     // 0xa4 x9 = x0 + x1
    add_word(enc_addi(10, 0, -1));               // 0xa8 x10 = -1
    add_word(32'h0000_0000);                     // 0xac illegal
    add_word(enc_branch(0, 1, 9, 12));           // 0xb0 BEQ taken to 0xbc
    add_word(enc_addi(11, 0, 1));                // 0xb4 shadow
    add_word(enc_addi(11, 0, 2));                // 0xb8 shadow
    add_word(enc_branch(1, 1, 2, 8));            // 0xbc BNE taken to 0xc4
    add_word(enc_addi(12, 0, 3));                // 0xc0 shadow
    add_word(enc_branch(0, 1, 2, 8));            // 0xc4 BEQ not taken
    add_word(enc_r(7'h20, 3'b000, 12, 10, 1));   // 0xc8 SUB x12 = -6
    add_word(enc_branch(1, 12, 12, -8));         // 0xcc BNE not taken
    add_word(enc_addi(13, 12, 6));               // 0xd0 x13 = 0
    add_word(enc_r(7'h20, 3'b110, 15, 1, 2));    // 0xd4 illegal funct7 on OR
    add_word(enc_r(7'h00, 3'b000, 14, 15, 10));  // 0xd8 x15 still zero

    add_expected(32'h80, 1, 1, 32'h0000_0005);
    add_expected(32'h84, 2, 1, 32'h0000_0008);
    add_expected(32'h88, 3, 1, 32'h0000_000d);
    add_expected(32'h8c, 4, 1, 32'h0000_0008);
    add_expected(32'h90, 5, 1, 32'h1234_5000);
    add_expected(32'h94, 6, 1, 32'h1234_500d);
    add_expected(32'h98, 7, 1, 32'h1234_5005);
    add_expected(32'h9c, 8, 1, 32'h1234_5005);
    add_expected(32'ha0, 0, 0, 32'h0000_000c);
    add_expected(32'ha4, 9, 1, 32'h0000_0005);
    add_expected(32'ha8, 10, 1, 32'hffff_ffff);
    add_expected(32'hb0, 0, 0, 32'h0000_0000);
    add_expected(32'hbc, 0, 0, 32'h0000_0000);
    add_expected(32'hc4, 0, 0, 32'h0000_0000);
    add_expected(32'hc8, 12, 1, 32'hffff_fffa);
    add_expected(32'hcc, 0, 0, 32'h0000_0000);
    add_expected(32'hd0, 13, 1, 32'h0000_0000);
    add_expected(32'hd8, 14, 1, 32'hffff_ffff);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    rst_n     = 1'b0;
    boot_addr = BOOT_ADDR;
    perf_sel  = `PERF_SEL_RETIRED;
    load_tables();
    if (n_words != N_PROG || n_expected != N_EXP) begin
      $display("Program or commit table size differs from its declared length");
      $display("sim failed");
      $fatal(1);
    end

    // No commits while in reset, pc held at boot address
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      check_value("commit_valid_o", 32'(commit_valid), 32'd0);
      check_value("instr_addr_o", instr_addr, boot_addr);
    end
    @(posedge clk);
    #1 rst_n = 1'b1;

    for (int i = 0; i < N_EXP; i++) begin
      do @(negedge clk); while (!commit_valid);
      check_value("commit_o.pc", commit.pc, exp_pc[i]);
      check_value("commit_o.we", 32'(commit.we), exp_we[i]);
      // rd and wdata only matter for a real register write
      if (exp_we[i] != 0) begin
        check_value("commit_o.rd", 32'(commit.rd), exp_rd[i]);
        check_value("commit_o.wdata", commit.wdata, exp_wdata[i]);
      end
    end

    // Past the program only zero words are fetched
    repeat (10) begin
      @(negedge clk);
      check_value("commit_valid_o", 32'(commit_valid), 32'd0);
    end

    @(posedge clk);
    #1 perf_sel = `PERF_SEL_RETIRED;
    @(negedge clk);
    check_value("perf_data_o", perf_data, 32'(N_EXP));
    @(posedge clk);
    #1 perf_sel = `PERF_SEL_BRANCH;
    @(negedge clk);
    check_value("perf_data_o", perf_data, 32'(N_TAKEN));

    $display("sim passed");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: commits stopped arriving before the end of the commit table");
    $display("sim failed");
    $fatal(1);
  end

endmodule

// ==== list.f ====
+incdir+source
source/rv_core_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/perf_counters.sv
source/rv_core.sv
dv/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f list.f \
  --top-module tb_rv_core -o tb_rv_core > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_rv_core > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -qx "sim passed" sim.log && echo "Result: PASS" || { echo "Result: FAIL"; exit 1; }

// ==== source/decode_stage.sv ====
`include "rv_core_params.svh"

module decode_stage import rv_core_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  fetch_entry_t           fetch_i,
  output logic [`REG_ADDR_W-1:0] raddr_a_o,
  output logic [`REG_ADDR_W-1:0] raddr_b_o,
  input  logic [`XLEN-1:0]       rdata_a_i,
  input  logic [`XLEN-1:0]       rdata_b_i,
  input  commit_t                fwd_i,
  output decoded_t               decoded_o
);

  instr_u           ins;
  logic [`XLEN-1:0] rs1_val;
  logic [`XLEN-1:0] rs2_val;
  logic             legal;
  logic             writes_rd;
  decoded_t         dec_d;
  decoded_t         payload_q;
  logic             valid_q;

  assign ins = fetch_i.instr;

  // --------------------------------------------------
  // Register read with bypass from execute
  // --------------------------------------------------
  // Source fields sit at the same bits in every format
  assign raddr_a_o = ins.r_type.rs1;
  assign raddr_b_o = ins.r_type.rs2;

  assign rs1_val = (fwd_i.we && fwd_i.rd == ins.r_type.rs1) ? fwd_i.wdata : rdata_a_i;
  assign rs2_val = (fwd_i.we && fwd_i.rd == ins.r_type.rs2) ? fwd_i.wdata : rdata_b_i;

  // --------------------------------------------------
  // Decoder
  // --------------------------------------------------
  always_comb begin
    dec_d           = '0;
    legal           = 1'b0;
    writes_rd       = 1'b0;
    dec_d.pc        = fetch_i.pc;
    dec_d.alu_op    = ALU_ADD;
    dec_d.operand_a = rs1_val;
    dec_d.operand_b = rs2_val;
    dec_d.rd        = ins.r_type.rd;

    case (ins.r_type.opcode)
      OPC_OP: begin
        legal     = 1'b1;
        writes_rd = 1'b1;
        case ({ins.r_type.funct7, ins.r_type.funct3})
          {7'b0000000, 3'b000}: dec_d.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: dec_d.alu_op = ALU_SUB;
          {7'b0000000, 3'b100}: dec_d.alu_op = ALU_XOR;
          {7'b0000000, 3'b110}: dec_d.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: dec_d.alu_op = ALU_AND;
          default:              legal        = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        // ADDI only
        legal           = (ins.i_type.funct3 == 3'b000);
        writes_rd       = 1'b1;
        dec_d.operand_b = {{(`XLEN-12){ins.i_type.imm[11]}}, ins.i_type.imm};
      end
      OPC_LUI: begin
        legal           = 1'b1;
        writes_rd       = 1'b1;
        dec_d.alu_op    = ALU_PASS_B;
        dec_d.operand_b = {ins.u_type.imm31_12, 12'b0};
      end
      OPC_BRANCH: begin
        legal               = (ins.b_type.funct3[2:1] == 2'b00);
        dec_d.alu_op        = ins.b_type.funct3[0] ? ALU_BNE : ALU_BEQ;
        dec_d.branch_offset = {{(`XLEN-13){ins.b_type.imm12}}, ins.b_type.imm12,
                               ins.b_type.imm11, ins.b_type.imm10_5,
                               ins.b_type.imm4_1, 1'b0};
      end
      default: legal = 1'b0;
    endcase

    // Writes to x0 are dropped here once
    dec_d.we    = writes_rd && (ins.r_type.rd != '0);
    dec_d.valid = fetch_i.valid && legal;
  end

  // --------------------------------------------------
  // Decode register toward execute
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= dec_d.valid && !flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    payload_q <= dec_d;
  end

  always_comb begin
    decoded_o       = payload_q;
    decoded_o.valid = valid_q;
  end

  // Fetch drops the word it takes during a flush
  a_flush_clears_fetch: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !fetch_i.valid
  );

endmodule

// ==== source/execute_stage.sv ====
`include "rv_core_params.svh"

module execute_stage import rv_core_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  decoded_t         decoded_i,
  output logic             flush_o,
  output logic [`XLEN-1:0] target_o,
  output commit_t          wb_o,
  output logic             retire_o,
  output logic             branch_taken_o,
  output logic             commit_valid_o,
  output commit_t          commit_o
);

  logic [`XLEN-1:0] result;
  logic             taken;
  logic             commit_valid_q;
  commit_t          commit_q;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    case (decoded_i.alu_op)
      ALU_ADD:    result = decoded_i.operand_a + decoded_i.operand_b;
      ALU_SUB:    result = decoded_i.operand_a - decoded_i.operand_b;
      ALU_AND:    result = decoded_i.operand_a & decoded_i.operand_b;
      ALU_OR:     result = decoded_i.operand_a | decoded_i.operand_b;
      ALU_XOR:    result = decoded_i.operand_a ^ decoded_i.operand_b;
      ALU_PASS_B: result = decoded_i.operand_b;
      default:    result = '0;
    endcase
  end

  // --------------------------------------------------
  // Branch resolution
  // --------------------------------------------------
  always_comb begin
    taken = 1'b0;
    if (decoded_i.valid) begin
      if (decoded_i.alu_op == ALU_BEQ) begin
        taken = (decoded_i.operand_a == decoded_i.operand_b);
      end else if (decoded_i.alu_op == ALU_BNE) begin
        taken = (decoded_i.operand_a != decoded_i.operand_b);
      end
    end
  end

  // Not-taken is the static guess, so only taken redirects
  assign flush_o        = taken;
  assign target_o       = decoded_i.pc + decoded_i.branch_offset;
  assign branch_taken_o = taken;
  assign retire_o       = decoded_i.valid;

  // Write-back and bypass
  always_comb begin
    wb_o.pc    = decoded_i.pc;
    wb_o.rd    = decoded_i.rd;
    wb_o.we    = decoded_i.valid && decoded_i.we;
    wb_o.wdata = result;
  end

  // --------------------------------------------------
  // Commit port
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_valid_q <= 1'b0;
    end else begin
      commit_valid_q <= decoded_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    commit_q <= wb_o;
  end

  assign commit_valid_o = commit_valid_q;
  assign commit_o       = commit_q;

  // Shadow instruction behind a taken branch must be killed in decode
  a_flush_kills_shadow: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_o |=> !decoded_i.valid
  );

endmodule

// ==== source/fetch_stage.sv ====
`include "rv_core_params.svh"

module fetch_stage import rv_core_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [`XLEN-1:0] boot_addr_i,
  input  logic             flush_i,
  input  logic [`XLEN-1:0] target_i,
  output logic [`XLEN-1:0] instr_addr_o,
  input  instr_u           instr_i,
  output fetch_entry_t     fetch_o
);

  logic [`XLEN-1:0] pc_q;
  logic             valid_q;
  logic [`XLEN-1:0] fetch_pc_q;
  instr_u           instr_q;

  // --------------------------------------------------
  // Program counter
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q    <= boot_addr_i;
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // Word fetched this cycle lies in the branch shadow
      pc_q    <= target_i;
      valid_q <= 1'b0;
    end else begin
      pc_q    <= pc_q + `XLEN'(4);
      valid_q <= 1'b1;
    end
  end

  assign instr_addr_o = pc_q;

  // Fetch register toward decode
  always_ff @(posedge clk_i) begin
    fetch_pc_q <= pc_q;
    instr_q    <= instr_i;
  end

  always_comb begin
    fetch_o.valid = valid_q;
    fetch_o.pc    = fetch_pc_q;
    fetch_o.instr = instr_q;
  end

endmodule

// ==== source/perf_counters.sv ====
`include "rv_core_params.svh"

module perf_counters import rv_core_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   retire_i,
  input  logic                   branch_taken_i,
  input  logic                   perf_sel_i,
  output logic [`PERF_CNT_W-1:0] perf_data_o
);

  logic [`PERF_CNT_W-1:0] retired_q;
  logic [`PERF_CNT_W-1:0] branch_q;

  // Both counters wrap on overflow
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retired_q <= '0;
      branch_q  <= '0;
    end else begin
      if (retire_i) begin
        retired_q <= retired_q + `PERF_CNT_W'(1);
      end
      if (branch_taken_i) begin
        branch_q <= branch_q + `PERF_CNT_W'(1);
      end
    end
  end

  // Read port
  always_comb begin
    case (perf_sel_i)
      `PERF_SEL_RETIRED: perf_data_o = retired_q;
      `PERF_SEL_BRANCH:  perf_data_o = branch_q;
    endcase
  end

endmodule

// ==== source/register_file.sv ====
`include "rv_core_params.svh"

module register_file import rv_core_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`REG_ADDR_W-1:0] raddr_b_i,
  input  logic [`REG_ADDR_W-1:0] waddr_i,
  input  logic                   we_i,
  input  logic [`XLEN-1:0]       wdata_i,
  output logic [`XLEN-1:0]       rdata_a_o,
  output logic [`XLEN-1:0]       rdata_b_o
);

  logic [`XLEN-1:0] regs_q [`NR_REGS];

  // Entry 0 is never written, so x0 keeps its reset value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  // Execute only writes for decoded rd != 0
  a_no_write_x0: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    we_i |-> waddr_i != '0
  );

endmodule

// ==== source/rv_core.sv ====
`include "rv_core_params.svh"

module rv_core import rv_core_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`XLEN-1:0]       boot_addr_i,
  output logic [`XLEN-1:0]       instr_addr_o,
  input  instr_u                 instr_i,
  input  logic                   perf_sel_i,
  output logic [`PERF_CNT_W-1:0] perf_data_o,
  output logic                   commit_valid_o,
  output commit_t                commit_o
);

  // --------------------------------------------------
  // Stage interconnect
  // --------------------------------------------------
  fetch_entry_t           fetch_entry;
  decoded_t               decoded;
  commit_t                wb;
  logic                   flush;
  logic [`XLEN-1:0]       target;
  logic [`REG_ADDR_W-1:0] raddr_a;
  logic [`REG_ADDR_W-1:0] raddr_b;
  logic [`XLEN-1:0]       rdata_a;
  logic [`XLEN-1:0]       rdata_b;
  logic                   retire;
  logic                   branch_taken;

  fetch_stage fetch_stage_i (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .boot_addr_i  ( boot_addr_i  ),
    .flush_i      ( flush        ),
    .target_i     ( target       ),
    .instr_addr_o ( instr_addr_o ),
    .instr_i      ( instr_i      ),
    .fetch_o      ( fetch_entry  )
  );

  decode_stage decode_stage_i (
    .clk_i     ( clk_i       ),
    .rst_ni    ( rst_ni      ),
    .flush_i   ( flush       ),
    .fetch_i   ( fetch_entry ),
    .raddr_a_o ( raddr_a     ),
    .raddr_b_o ( raddr_b     ),
    .rdata_a_i ( rdata_a     ),
    .rdata_b_i ( rdata_b     ),
    .fwd_i     ( wb          ),
    .decoded_o ( decoded     )
  );

  register_file register_file_i (
    .clk_i     ( clk_i    ),
    .rst_ni    ( rst_ni   ),
    .raddr_a_i ( raddr_a  ),
    .raddr_b_i ( raddr_b  ),
    .waddr_i   ( wb.rd    ),
    .we_i      ( wb.we    ),
    .wdata_i   ( wb.wdata ),
    .rdata_a_o ( rdata_a  ),
    .rdata_b_o ( rdata_b  )
  );

  execute_stage execute_stage_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .decoded_i      ( decoded        ),
    .flush_o        ( flush          ),
    .target_o       ( target         ),
    .wb_o           ( wb             ),
    .retire_o       ( retire         ),
    .branch_taken_o ( branch_taken   ),
    .commit_valid_o ( commit_valid_o ),
    .commit_o       ( commit_o       )
  );

  perf_counters perf_counters_i (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .retire_i       ( retire       ),
    .branch_taken_i ( branch_taken ),
    .perf_sel_i     ( perf_sel_i   ),
    .perf_data_o    ( perf_data_o  )
  );

endmodule

// ==== source/rv_core_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
`define XLEN 32
`define NR_REGS 32
`define REG_ADDR_W 5

// --------------------------------------------------
// Performance counters
// --------------------------------------------------
`define PERF_CNT_W 32

// Select codes of the counter read port
`define PERF_SEL_RETIRED 1'b0
`define PERF_SEL_BRANCH 1'b1

`endif

// ==== source/rv_core_pkg.sv ====
`include "rv_core_params.svh"

package rv_core_pkg;

  // --------------------------------------------------
  // Opcodes of the supported RV32I subset
  // --------------------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // --------------------------------------------------
  // Instruction formats
  // --------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // Branch immediate is scattered over two fields
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  // One instruction word, decoded per format
  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    b_type_t b_type;
    u_type_t u_type;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B,
    ALU_BEQ,
    ALU_BNE
  } alu_op_e;

  // --------------------------------------------------
  // Pipeline payloads
  // --------------------------------------------------
  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    instr_u                 instr;
  } fetch_entry_t;

  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    alu_op_e                alu_op;
    logic [`XLEN-1:0]       operand_a;
    logic [`XLEN-1:0]       operand_b;
    logic [`XLEN-1:0]       branch_offset;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   we;
  } decoded_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   we;
    logic [`XLEN-1:0]       wdata;
  } commit_t;

endpackage
